// File: common/riscv_pkg.sv
////////////////////
// riscv pipeline control package
// register index, control codes, stage info and hazard bus types
////////////////////
`default_nettype none

package riscv_pkg;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // index of the hardwired zero register
    localparam reg_idx_t REG_ZERO = 5'd0;

    // pipeline registers followed by the tracker: dec/ex, ex/mem, mem/wb
    localparam int unsigned TRACKED_STAGES = 3;

    // command for one pipeline register
    typedef enum logic [1:0] {
        ENABLE = 2'b00,  // load next value
        STALL  = 2'b01,  // hold current value
        FLUSH  = 2'b10   // load a bubble
    } hazard_ctrl_e;

    // memory access request
    typedef enum logic {
        NO_REQUEST = 1'b0,
        REQUEST    = 1'b1
    } mem_req_e;

    // memory access direction
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } mem_we_e;

    // memory side of an instruction
    typedef struct packed {
        mem_req_e proc_req;
        mem_we_e  we;
    } mem_ctrl_t;

    // register fields of one in-flight instruction
    typedef struct packed {
        logic      valid;
        logic      reg_write;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        mem_ctrl_t mem;
    } stage_info_t;

    // empty slot, what a flush loads
    localparam stage_info_t BUBBLE = '{
        valid:     1'b0,
        reg_write: 1'b0,
        rd:        REG_ZERO,
        rs1:       REG_ZERO,
        rs2:       REG_ZERO,
        mem:       '{proc_req: NO_REQUEST, we: READ}
    };

    // one command per pipeline register, pc first
    typedef struct packed {
        hazard_ctrl_e pc_reg;
        hazard_ctrl_e if_dec;
        hazard_ctrl_e dec_ex;
        hazard_ctrl_e ex_mem;
        hazard_ctrl_e mem_wb;
    } hazard_bus_t;

    // source of an ex operand
    typedef enum logic [1:0] {
        FWD_RF     = 2'b00,  // register file value
        FWD_EX_MEM = 2'b01,  // alu result one stage ahead
        FWD_MEM_WB = 2'b10   // writeback value two stages ahead
    } fwd_sel_e;

    // a load is a read request to data memory
    function automatic logic is_load(mem_ctrl_t m);
        return (m.proc_req == REQUEST) && (m.we == READ);
    endfunction

endpackage

`default_nettype wire

// File: hdl/hu.sv
////////////////////
// hazard unit
// computes stall and flush commands for the five pipeline registers
// from branch, load-use and memory busy conditions
////////////////////
`timescale 1ns/1ps
`default_nettype none

module hu (
    input  logic                   en,
    input  logic                   branch_taken,
    input  logic                   instr_mem_busy,
    input  logic                   data_mem_busy,
    input  riscv_pkg::stage_info_t dec_info,
    input  riscv_pkg::stage_info_t dec_ex_info,
    output riscv_pkg::hazard_bus_t hazard
);
    import riscv_pkg::*;

    logic mem_busy;
    logic ld_valid;
    logic rs_match;
    logic load_use;
    logic any_flush;

    // either memory not ready freezes the whole pipe
    assign mem_busy = instr_mem_busy | data_mem_busy;

    // real load sitting in ex, x0 never counts
    assign ld_valid = dec_ex_info.valid
                    & is_load(dec_ex_info.mem)
                    & (dec_ex_info.rd != REG_ZERO);

    // decode instruction reads the load target
    assign rs_match = (dec_ex_info.rd == dec_info.rs1)
                    | (dec_ex_info.rd == dec_info.rs2);

    assign load_use = ld_valid & dec_info.valid & rs_match;

    always_comb begin
        // everything advances unless told otherwise
        hazard.pc_reg = ENABLE;
        hazard.if_dec = ENABLE;
        hazard.dec_ex = ENABLE;
        hazard.ex_mem = ENABLE;
        hazard.mem_wb = ENABLE;

        if (en) begin
            // wrong-path instruction in decode
            if (branch_taken) begin
                hazard.if_dec = FLUSH;
            end

            // hold consumer in decode, bubble into ex
            if (load_use) begin
                hazard.pc_reg = STALL;
                hazard.if_dec = STALL;
                hazard.dec_ex = FLUSH;
            end

            // busy wins over both, nothing is dropped
            if (mem_busy) begin
                hazard.pc_reg = STALL;
                hazard.if_dec = STALL;
                hazard.dec_ex = STALL;
                hazard.ex_mem = STALL;
                hazard.mem_wb = STALL;
            end
        end
    end

    assign any_flush = (hazard.pc_reg == FLUSH) | (hazard.if_dec == FLUSH)
                     | (hazard.dec_ex == FLUSH) | (hazard.ex_mem == FLUSH)
                     | (hazard.mem_wb == FLUSH);

    // a frozen pipe must not lose an instruction
    always_comb begin
        a_busy_no_flush : assert #0 (!mem_busy || !any_flush);
    end

    // holding ex while decode moves on would overwrite the held slot's successor
    always_comb begin
        a_dec_ex_stall_order : assert #0
            (!(hazard.dec_ex == STALL && hazard.if_dec == ENABLE));
    end

endmodule

`default_nettype wire

// File: hdl/stage_tracker.sv
////////////////////
// stage tracker
// dec/ex, ex/mem and mem/wb registers of instruction fields,
// each one advanced, held or bubbled by its hazard command
////////////////////
`timescale 1ns/1ps
`default_nettype none

module stage_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  riscv_pkg::hazard_bus_t hazard,
    input  riscv_pkg::stage_info_t dec_info,
    output riscv_pkg::stage_info_t dec_ex_info,
    output riscv_pkg::stage_info_t ex_mem_info,
    output riscv_pkg::stage_info_t mem_wb_info
);
    import riscv_pkg::*;

    // index 0 is dec/ex, 1 ex/mem, 2 mem/wb
    hazard_ctrl_e ctrl   [TRACKED_STAGES];
    stage_info_t  prev   [TRACKED_STAGES];
    stage_info_t  regs_q [TRACKED_STAGES];

    // command for each register
    assign ctrl[0] = hazard.dec_ex;
    assign ctrl[1] = hazard.ex_mem;
    assign ctrl[2] = hazard.mem_wb;

    // what each register loads on enable
    assign prev[0] = dec_info;
    assign prev[1] = regs_q[0];
    assign prev[2] = regs_q[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // pipe starts empty
            for (int i = 0; i < TRACKED_STAGES; i++) begin
                regs_q[i] <= BUBBLE;
            end
        end else begin
            for (int i = 0; i < TRACKED_STAGES; i++) begin
                case (ctrl[i])
                    ENABLE:  regs_q[i] <= prev[i];
                    FLUSH:   regs_q[i] <= BUBBLE;
                    // stall, and the unused code, hold
                    default: regs_q[i] <= regs_q[i];
                endcase
            end
        end
    end

    assign dec_ex_info = regs_q[0];
    assign ex_mem_info = regs_q[1];
    assign mem_wb_info = regs_q[2];

    // per-register checks of the command the cycle before
    for (genvar g = 0; g < TRACKED_STAGES; g++) begin : g_chk
        // flushed slot is empty next cycle
        a_flush_bubble : assert property (
            @(posedge clk) disable iff (!rst_n)
            ctrl[g] == FLUSH |=> !regs_q[g].valid
        );

        // stalled slot keeps every field
        a_stall_hold : assert property (
            @(posedge clk) disable iff (!rst_n)
            ctrl[g] == STALL |=> $stable(regs_q[g])
        );
    end

endmodule

`default_nettype wire

// File: hdl/fwd_unit.sv
////////////////////
// forwarding unit
// picks the source of each ex operand from the later stages
////////////////////
`timescale 1ns/1ps
`default_nettype none

module fwd_unit (
    input  riscv_pkg::stage_info_t dec_ex_info,
    input  riscv_pkg::stage_info_t ex_mem_info,
    input  riscv_pkg::stage_info_t mem_wb_info,
    output riscv_pkg::fwd_sel_e    fwd_rs1,
    output riscv_pkg::fwd_sel_e    fwd_rs2
);
    import riscv_pkg::*;

    // producer will write src, x0 excluded
    function automatic logic writes_src(stage_info_t producer, reg_idx_t src);
        return producer.valid
            && producer.reg_write
            && (producer.rd != REG_ZERO)
            && (producer.rd == src);
    endfunction

    // nearest producer wins
    function automatic fwd_sel_e select_src(stage_info_t consumer, reg_idx_t src,
                                            stage_info_t ex_mem, stage_info_t mem_wb);
        fwd_sel_e sel;
        sel = FWD_RF;
        if (consumer.valid) begin
            // load data not ready until mem/wb
            if (writes_src(ex_mem, src) && !is_load(ex_mem.mem)) begin
                sel = FWD_EX_MEM;
            end else if (writes_src(mem_wb, src)) begin
                sel = FWD_MEM_WB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd_rs1 = select_src(dec_ex_info, dec_ex_info.rs1, ex_mem_info, mem_wb_info);
        fwd_rs2 = select_src(dec_ex_info, dec_ex_info.rs2, ex_mem_info, mem_wb_info);
    end

    // load value only exists after mem, the load-use stall covers the gap
    always_comb begin
        a_no_load_fwd : assert #0 (!is_load(ex_mem_info.mem)
            || (fwd_rs1 != FWD_EX_MEM && fwd_rs2 != FWD_EX_MEM));
    end

endmodule

`default_nettype wire

// File: hdl/pipe_ctrl_top.sv
////////////////////
// pipeline control top
// stage tracker, hazard unit and forwarding unit
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic                   branch_taken,
    input  logic                   instr_mem_busy,
    input  logic                   data_mem_busy,
    input  riscv_pkg::stage_info_t dec_info,
    output riscv_pkg::hazard_bus_t hazard,
    output riscv_pkg::fwd_sel_e    fwd_rs1,
    output riscv_pkg::fwd_sel_e    fwd_rs2
);
    import riscv_pkg::*;

    // instruction fields in ex, mem and wb
    stage_info_t dec_ex_info;
    stage_info_t ex_mem_info;
    stage_info_t mem_wb_info;

    // registers advance under the hazard commands
    stage_tracker u_stage_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .hazard      (hazard),
        .dec_info    (dec_info),
        .dec_ex_info (dec_ex_info),
        .ex_mem_info (ex_mem_info),
        .mem_wb_info (mem_wb_info)
    );

    // decode vs ex for load-use
    hu u_hu (
        .en             (en),
        .branch_taken   (branch_taken),
        .instr_mem_busy (instr_mem_busy),
        .data_mem_busy  (data_mem_busy),
        .dec_info       (dec_info),
        .dec_ex_info    (dec_ex_info),
        .hazard         (hazard)
    );

    // operand muxes for ex
    fwd_unit u_fwd_unit (
        .dec_ex_info (dec_ex_info),
        .ex_mem_info (ex_mem_info),
        .mem_wb_info (mem_wb_info),
        .fwd_rs1     (fwd_rs1),
        .fwd_rs2     (fwd_rs2)
    );

endmodule

`default_nettype wire

// File: verification/pipe_ctrl_vectors.svh
////////////////////
// pipeline control test vectors
// instruction builders and the per-cycle stimulus and expected table
////////////////////
`ifndef PIPE_CTRL_VECTORS_SVH
`define PIPE_CTRL_VECTORS_SVH

// alu instruction writing rd
function automatic stage_info_t alu_op(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    stage_info_t info;
    info           = BUBBLE;
    info.valid     = 1'b1;
    info.reg_write = 1'b1;
    info.rd        = rd;
    info.rs1       = rs1;
    info.rs2       = rs2;
    return info;
endfunction

// load, base address in rs1
function automatic stage_info_t load_op(reg_idx_t rd, reg_idx_t rs1);
    stage_info_t info;
    info              = alu_op(rd, rs1, REG_ZERO);
    info.mem.proc_req = REQUEST;
    info.mem.we       = READ;
    return info;
endfunction

// no instruction in decode, register fields get random values when added
function automatic stage_info_t empty_slot();
    return BUBBLE;
endfunction

// cond bits: {en, branch_taken, instr_mem_busy, data_mem_busy}
task automatic build_table();
    // idle pipe after reset, then a taken branch
    add_row("reset_idle", 4'b1000, empty_slot(), no_hazard(), FWD_RF, FWD_RF);
    add_row("branch_flush", 4'b1100, empty_slot(), branch_flush(), FWD_RF, FWD_RF);
    add_row("after_branch", 4'b1000, empty_slot(), no_hazard(), FWD_RF, FWD_RF);

    // load x5 then reader of x5, consumer held one cycle in decode
    add_row("lu_load", 4'b1000, load_op(5, 1), no_hazard(), FWD_RF, FWD_RF);
    add_row("lu_stall", 4'b1000, alu_op(6, 5, 2), load_use_stall(), FWD_RF, FWD_RF);
    add_row("lu_bubble", 4'b1000, alu_op(6, 5, 2), no_hazard(), FWD_RF, FWD_RF);
    add_row("lu_wb_fwd", 4'b1000, empty_slot(), no_hazard(), FWD_MEM_WB, FWD_RF);

    // same pair on x0, no stall
    add_row("x0_load", 4'b1000, load_op(0, 1), no_hazard(), FWD_RF, FWD_RF);
    add_row("x0_reader", 4'b1000, alu_op(7, 0, 0), no_hazard(), FWD_RF, FWD_RF);
    add_row("x0_drain", 4'b1000, empty_slot(), no_hazard(), FWD_RF, FWD_RF);

    // ex/mem forward set up, then frozen by either busy
    add_row("busy_writer", 4'b1000, alu_op(8, 1, 2), no_hazard(), FWD_RF, FWD_RF);
    add_row("busy_reader", 4'b1000, alu_op(9, 8, 3), no_hazard(), FWD_RF, FWD_RF);
    add_row("imem_busy", 4'b1010, load_op(10, 4), busy_stall(), FWD_EX_MEM, FWD_RF);
    add_row("dmem_busy", 4'b1001, load_op(10, 4), busy_stall(), FWD_EX_MEM, FWD_RF);
    add_row("busy_release", 4'b1000, load_op(10, 4), no_hazard(), FWD_EX_MEM, FWD_RF);

    // busy wins over load-use and branch
    add_row("busy_lu", 4'b1001, alu_op(11, 10, 10), busy_stall(), FWD_RF, FWD_RF);
    add_row("busy_lu_branch", 4'b1110, alu_op(11, 10, 10), busy_stall(), FWD_RF, FWD_RF);
    add_row("lu_after_busy", 4'b1000, alu_op(11, 10, 10), load_use_stall(), FWD_RF, FWD_RF);
    add_row("lu_after_busy_go", 4'b1000, alu_op(11, 10, 10), no_hazard(), FWD_RF, FWD_RF);
    add_row("ld_wb_fwd_both", 4'b1000, empty_slot(), no_hazard(), FWD_MEM_WB, FWD_MEM_WB);

    // two writers of x12, nearest one wins
    add_row("fwd_wr_a", 4'b1000, alu_op(12, 1, 2), no_hazard(), FWD_RF, FWD_RF);
    add_row("fwd_wr_b", 4'b1000, alu_op(12, 3, 4), no_hazard(), FWD_RF, FWD_RF);
    add_row("fwd_reader", 4'b1000, alu_op(13, 12, 5), no_hazard(), FWD_RF, FWD_RF);
    add_row("fwd_ex_mem_pri", 4'b1000, empty_slot(), no_hazard(), FWD_EX_MEM, FWD_RF);

    // one instruction between writer and reader
    add_row("gap_writer", 4'b1000, alu_op(14, 1, 2), no_hazard(), FWD_RF, FWD_RF);
    add_row("gap_filler", 4'b1000, alu_op(15, 1, 2), no_hazard(), FWD_RF, FWD_RF);
    add_row("gap_reader", 4'b1000, alu_op(16, 3, 14), no_hazard(), FWD_RF, FWD_RF);
    add_row("gap_wb_fwd", 4'b1000, empty_slot(), no_hazard(), FWD_RF, FWD_MEM_WB);

    // load, filler, reader two cycles later
    add_row("ld2_load", 4'b1000, load_op(17, 1), no_hazard(), FWD_RF, FWD_RF);
    add_row("ld2_filler", 4'b1000, alu_op(18, 2, 3), no_hazard(), FWD_RF, FWD_RF);
    add_row("ld2_reader", 4'b1000, alu_op(19, 17, 17), no_hazard(), FWD_RF, FWD_RF);
    add_row("ld2_wb_fwd", 4'b1000, empty_slot(), no_hazard(), FWD_MEM_WB, FWD_MEM_WB);

    // en low, every hazard ignored; load in ex/mem is still never forwarded
    add_row("dis_load", 4'b0000, load_op(20, 1), no_hazard(), FWD_RF, FWD_RF);
    add_row("dis_all", 4'b0111, alu_op(21, 20, 2), no_hazard(), FWD_RF, FWD_RF);
    add_row("dis_branch", 4'b0100, empty_slot(), no_hazard(), FWD_RF, FWD_RF);
    add_row("reenable", 4'b1000, empty_slot(), no_hazard(), FWD_RF, FWD_RF);
endtask

`endif

// File: verification/pipe_ctrl_tb.sv
////////////////////
// pipeline control testbench
// runs the vector table through pipe_ctrl_top, checks controls and selects
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_tb;
    import riscv_pkg::*;

    // one table row, its name sits in row_names at the same index
    typedef struct packed {
        logic        en;
        logic        branch_taken;
        logic        instr_mem_busy;
        logic        data_mem_busy;
        stage_info_t dec_info;
        hazard_bus_t exp_hazard;
        fwd_sel_e    exp_rs1;
        fwd_sel_e    exp_rs2;
    } vec_row_t;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        branch_taken;
    logic        instr_mem_busy;
    logic        data_mem_busy;
    stage_info_t dec_info;
    hazard_bus_t hazard;
    fwd_sel_e    fwd_rs1;
    fwd_sel_e    fwd_rs2;

    vec_row_t rows[$];
    string    row_names[$];
    int       checks;
    int       errors;

    pipe_ctrl_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .branch_taken   (branch_taken),
        .instr_mem_busy (instr_mem_busy),
        .data_mem_busy  (data_mem_busy),
        .dec_info       (dec_info),
        .hazard         (hazard),
        .fwd_rs1        (fwd_rs1),
        .fwd_rs2        (fwd_rs2)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // expected control patterns, pc first
    function automatic hazard_bus_t no_hazard();
        return '{ENABLE, ENABLE, ENABLE, ENABLE, ENABLE};
    endfunction

    function automatic hazard_bus_t branch_flush();
        return '{ENABLE, FLUSH, ENABLE, ENABLE, ENABLE};
    endfunction

    function automatic hazard_bus_t load_use_stall();
        return '{STALL, STALL, FLUSH, ENABLE, ENABLE};
    endfunction

    function automatic hazard_bus_t busy_stall();
        return '{STALL, STALL, STALL, STALL, STALL};
    endfunction

    task automatic add_row(string name, logic [3:0] cond, stage_info_t info,
                           hazard_bus_t exp_hazard, fwd_sel_e exp_rs1, fwd_sel_e exp_rs2);
        vec_row_t    row;
        logic [31:0] rnd;
        // fields of an invalid slot never reach a result
        if (!info.valid) begin
            rnd      = $urandom();
            info.rd  = rnd[4:0];
            info.rs1 = rnd[9:5];
            info.rs2 = rnd[14:10];
        end
        row.en             = cond[3];
        row.branch_taken   = cond[2];
        row.instr_mem_busy = cond[1];
        row.data_mem_busy  = cond[0];
        row.dec_info       = info;
        row.exp_hazard     = exp_hazard;
        row.exp_rs1        = exp_rs1;
        row.exp_rs2        = exp_rs2;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    `include "pipe_ctrl_vectors.svh"

    task automatic apply_row(vec_row_t row);
        en             = row.en;
        branch_taken   = row.branch_taken;
        instr_mem_busy = row.instr_mem_busy;
        data_mem_busy  = row.data_mem_busy;
        dec_info       = row.dec_info;
    endtask

    function automatic string hazard_text(hazard_bus_t h);
        return $sformatf("pc=%s if_dec=%s dec_ex=%s ex_mem=%s mem_wb=%s",
                         h.pc_reg.name(), h.if_dec.name(), h.dec_ex.name(),
                         h.ex_mem.name(), h.mem_wb.name());
    endfunction

    task automatic check_hazard(string name, hazard_bus_t expected, hazard_bus_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s hazard: expected %s, actual %s",
                     name, hazard_text(expected), hazard_text(actual));
        end
    endtask

    task automatic check_fwd(string name, string operand, fwd_sel_e expected,
                             fwd_sel_e actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected %s, actual %s",
                     name, operand, expected.name(), actual.name());
        end
    endtask

    initial begin
        void'($urandom(32'h6a04));
        checks         = 0;
        errors         = 0;
        clk            = 1'b0;
        rst_n          = 1'b0;
        en             = 1'b1;
        branch_taken   = 1'b0;
        instr_mem_busy = 1'b0;
        data_mem_busy  = 1'b0;
        dec_info       = BUBBLE;
        build_table();

        // reset over 4 cycles
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1;
            apply_row(rows[i]);
            // 1 ns before the next edge
            #98;
            check_hazard(row_names[i], rows[i].exp_hazard, hazard);
            check_fwd(row_names[i], "fwd_rs1", rows[i].exp_rs1, fwd_rs1);
            check_fwd(row_names[i], "fwd_rs2", rows[i].exp_rs2, fwd_rs2);
        end

        $display("rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // run limit is the table length plus reset and margin
    initial begin
        int unsigned limit;
        #1;
        limit = rows.size() + 20;
        repeat (limit) @(posedge clk);
        $display("timeout: the vector loop did not finish within %0d clock cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verification
common/riscv_pkg.sv
hdl/hu.sv
hdl/stage_tracker.sv
hdl/fwd_unit.sv
hdl/pipe_ctrl_top.sv
verification/pipe_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# verilator build and run of the pipeline control testbench
# exit status is nonzero when the log holds the failure line

set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module pipe_ctrl_tb \
    -f src.f \
    -o pipe_ctrl_sim \
    && ./obj_dir/pipe_ctrl_sim 2>&1 | tee "$log" \
    || { echo "build or simulation error"; exit 1; }

grep -q "Checks failed" "$log" && { echo "simulation failed"; exit 1; }
grep -q "All checks passed" "$log" || { echo "no pass line in $log"; exit 1; }
echo "simulation passed"
